//--- build.f
+incdir+.
ita_ctrl_pkg.sv
ita_tile_sequencer.sv
ita_outstanding_tracker.sv
ita_beat_gate.sv
ita_ctrl_top.sv
tb_clk_gen.sv
tb_ita_ctrl.sv

//--- ita_beat_gate.sv
/* input handshakes and beat counting
   tile_done is combinational and pulses on the final beat of a tile */

`timescale 1ns/1ns

`include "ita_settings.svh"

module ita_beat_gate (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  ita_ctrl_pkg::step_e step_i,
  input  logic                stall_i,
  input  logic                inp_valid_i,
  input  logic                weight_valid_i,
  input  logic                bias_valid_i,
  output logic                inp_ready_o,
  output logic                weight_ready_o,
  output logic                bias_ready_o,
  output logic                calc_en_o,
  output logic                tile_done_o
);

  ita_ctrl_pkg::counter_t beat_q;
  logic allow;

  assign allow = (step_i != ita_ctrl_pkg::Idle) && !stall_i;

  // input and weight pair up, bias follows the weight
  assign inp_ready_o    = allow & weight_valid_i;
  assign weight_ready_o = allow & inp_valid_i;
  assign bias_ready_o   = allow & weight_valid_i;

  assign calc_en_o   = allow & inp_valid_i & weight_valid_i & bias_valid_i;
  assign tile_done_o = calc_en_o &&
                       (beat_q == ita_ctrl_pkg::counter_t'(`ITA_BEATS_PER_TILE - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_q <= '0;
    end else if (tile_done_o) begin
      beat_q <= '0;
    end else if (calc_en_o) begin
      beat_q <= beat_q + ita_ctrl_pkg::counter_t'(1);
    end
  end

endmodule

//--- ita_ctrl_pkg.sv
/* types shared by the tile sequencing controller
   tile counts in ctrl_t are held stable while a layer runs */

`include "ita_settings.svh"

package ita_ctrl_pkg;

  typedef logic [`ITA_CNT_W-1:0] counter_t;

  typedef enum logic [1:0] {
    Idle   = 2'd0,
    MatMul = 2'd1, // linear layer
    F1     = 2'd2, // feedforward, first matmul
    F2     = 2'd3  // feedforward, second matmul
  } step_e;

  typedef enum logic {
    Linear      = 1'b0,
    Feedforward = 1'b1
  } layer_e;

  // layer setup from the host
  typedef struct packed {
    logic     start;
    layer_e   layer;
    counter_t tile_s; // sequence tiles
    counter_t tile_e; // embedding tiles
    counter_t tile_p; // projection tiles
    counter_t tile_f; // feedforward tiles
  } ctrl_t;

  // output position of the tile being computed
  typedef struct packed {
    counter_t tile_x;
    counter_t tile_y;
    counter_t inner_tile;
    logic     first_inner;
    logic     last_inner;
  } tile_pos_t;

endpackage

//--- ita_ctrl_top.sv
/* tile sequencing controller for linear and feedforward layers
   ctrl_i must stay stable from start until step_o is back at Idle */

`timescale 1ns/1ns

module ita_ctrl_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  ita_ctrl_pkg::ctrl_t     ctrl_i,
  input  logic                    inp_valid_i,
  output logic                    inp_ready_o,
  input  logic                    weight_valid_i,
  output logic                    weight_ready_o,
  input  logic                    bias_valid_i,
  output logic                    bias_ready_o,
  input  logic                    oup_valid_i,
  input  logic                    oup_ready_i,
  output ita_ctrl_pkg::step_e     step_o,
  output logic                    calc_en_o,
  output ita_ctrl_pkg::tile_pos_t tile_pos_o
);

  logic stall;
  logic tile_done;

  ita_tile_sequencer u_sequencer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ctrl_i      (ctrl_i),
    .tile_done_i (tile_done),
    .step_o      (step_o),
    .tile_pos_o  (tile_pos_o)
  );

  ita_outstanding_tracker u_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .calc_en_i    (calc_en_o),
    .last_inner_i (tile_pos_o.last_inner),
    .oup_valid_i  (oup_valid_i),
    .oup_ready_i  (oup_ready_i),
    .stall_o      (stall)
  );

  ita_beat_gate u_beat_gate (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .step_i         (step_o),
    .stall_i        (stall),
    .inp_valid_i    (inp_valid_i),
    .weight_valid_i (weight_valid_i),
    .bias_valid_i   (bias_valid_i),
    .inp_ready_o    (inp_ready_o),
    .weight_ready_o (weight_ready_o),
    .bias_ready_o   (bias_ready_o),
    .calc_en_o      (calc_en_o),
    .tile_done_o    (tile_done)
  );

endmodule

//--- ita_outstanding_tracker.sv
/* counts last-inner beats whose outputs have not left yet
   an output handshake with nothing in flight is ignored */

`timescale 1ns/1ns

`include "ita_settings.svh"

module ita_outstanding_tracker (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic calc_en_i,
  input  logic last_inner_i,
  input  logic oup_valid_i,
  input  logic oup_ready_i,
  output logic stall_o
);

  ita_ctrl_pkg::counter_t ongoing_q;
  logic push, pop;

  assign push = calc_en_i & last_inner_i; // beat that yields an output
  assign pop  = oup_valid_i & oup_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ongoing_q <= '0;
    end else if (push && !pop) begin
      ongoing_q <= ongoing_q + ita_ctrl_pkg::counter_t'(1);
    end else if (pop && !push && ongoing_q != '0) begin
      ongoing_q <= ongoing_q - ita_ctrl_pkg::counter_t'(1);
    end
  end

  // output FIFO full
  assign stall_o = (ongoing_q >= ita_ctrl_pkg::counter_t'(`ITA_FIFO_DEPTH));

endmodule

//--- ita_settings.svh
/* tile geometry and flow-control limits of the controller
   ITA_BEATS_PER_TILE and ITA_FIFO_DEPTH must fit in ITA_CNT_W bits */

`ifndef ITA_SETTINGS_SVH
`define ITA_SETTINGS_SVH

// tile edge in rows
`define ITA_M 8

// parallel lanes per beat
`define ITA_N 4

`define ITA_BEATS_PER_TILE ((`ITA_M * `ITA_M) / `ITA_N)

// outputs allowed in flight before the inputs stall
`define ITA_FIFO_DEPTH 4

// tile, beat and in-flight counters
`define ITA_CNT_W 8

`endif

//--- ita_tile_sequencer.sv
/* step FSM and tile counters for the linear and feedforward layers
   tile limits of zero are not supported, counters then run to wrap */

`timescale 1ns/1ns

module ita_tile_sequencer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  ita_ctrl_pkg::ctrl_t     ctrl_i,
  input  logic                    tile_done_i,
  output ita_ctrl_pkg::step_e     step_o,
  output ita_ctrl_pkg::tile_pos_t tile_pos_o
);

  ita_ctrl_pkg::step_e    step_d, step_q;
  ita_ctrl_pkg::counter_t inner_d, inner_q;
  ita_ctrl_pkg::counter_t tile_x_d, tile_x_q;
  ita_ctrl_pkg::counter_t tile_y_d, tile_y_q;
  ita_ctrl_pkg::counter_t tile_d, tile_q; // tiles done in this step

  ita_ctrl_pkg::counter_t inner_lim, x_lim, total_lim;

  // per-step loop limits
  always_comb begin
    case (step_q)
      ita_ctrl_pkg::MatMul: begin
        inner_lim = ctrl_i.tile_e;
        x_lim     = ctrl_i.tile_p;
        total_lim = ctrl_i.tile_s * ctrl_i.tile_p;
      end
      ita_ctrl_pkg::F1: begin
        inner_lim = ctrl_i.tile_e;
        x_lim     = ctrl_i.tile_f;
        total_lim = ctrl_i.tile_s * ctrl_i.tile_f;
      end
      ita_ctrl_pkg::F2: begin
        inner_lim = ctrl_i.tile_f; // inner loop runs over the hidden dim
        x_lim     = ctrl_i.tile_e;
        total_lim = ctrl_i.tile_s * ctrl_i.tile_e;
      end
      default: begin
        inner_lim = '0;
        x_lim     = '0;
        total_lim = '0;
      end
    endcase
  end

  always_comb begin
    step_d   = step_q;
    inner_d  = inner_q;
    tile_x_d = tile_x_q;
    tile_y_d = tile_y_q;
    tile_d   = tile_q;

    if (step_q == ita_ctrl_pkg::Idle) begin
      inner_d  = '0;
      tile_x_d = '0;
      tile_y_d = '0;
      tile_d   = '0;
      if (ctrl_i.start) begin
        step_d = (ctrl_i.layer == ita_ctrl_pkg::Feedforward) ? ita_ctrl_pkg::F1
                                                             : ita_ctrl_pkg::MatMul;
      end
    end else if (tile_done_i) begin
      if (inner_q == inner_lim - ita_ctrl_pkg::counter_t'(1)) begin // end of inner loop
        inner_d = '0;
        tile_d  = tile_q + ita_ctrl_pkg::counter_t'(1);
        if (tile_x_q == x_lim - ita_ctrl_pkg::counter_t'(1)) begin
          tile_x_d = '0;
          tile_y_d = tile_y_q + ita_ctrl_pkg::counter_t'(1);
        end else begin
          tile_x_d = tile_x_q + ita_ctrl_pkg::counter_t'(1);
        end
        if (tile_q == total_lim - ita_ctrl_pkg::counter_t'(1)) begin // last tile of step
          tile_d   = '0;
          tile_x_d = '0;
          tile_y_d = '0;
          step_d   = (step_q == ita_ctrl_pkg::F1) ? ita_ctrl_pkg::F2 : ita_ctrl_pkg::Idle;
        end
      end else begin
        inner_d = inner_q + ita_ctrl_pkg::counter_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q   <= ita_ctrl_pkg::Idle;
      inner_q  <= '0;
      tile_x_q <= '0;
      tile_y_q <= '0;
      tile_q   <= '0;
    end else begin
      step_q   <= step_d;
      inner_q  <= inner_d;
      tile_x_q <= tile_x_d;
      tile_y_q <= tile_y_d;
      tile_q   <= tile_d;
    end
  end

  assign step_o = step_q;

  // decoded from registers only, so it moves on the edge after tile_done
  assign tile_pos_o.tile_x      = tile_x_q;
  assign tile_pos_o.tile_y      = tile_y_q;
  assign tile_pos_o.inner_tile  = inner_q;
  assign tile_pos_o.first_inner = (inner_q == '0);
  assign tile_pos_o.last_inner  = (step_q != ita_ctrl_pkg::Idle) &&
                                  (inner_q == inner_lim - ita_ctrl_pkg::counter_t'(1));

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the controller testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -f build.f --top-module tb_ita_ctrl -o sim_ita_ctrl \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_ita_ctrl > sim.log 2>&1 || { cat sim.log; echo "run failed"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "All tests passed" sim.log || { echo "no pass message in log"; exit 1; }
exit 0

//--- tb_clk_gen.sv
/* testbench clock and active-low reset
   reset is released on a rising edge after reset_cycles cycles */

`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int period_ns    = 20,
  parameter int reset_cycles = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no <= 1'b0;
    repeat (reset_cycles) @(posedge clk_o);
    rst_no <= 1'b1; // released together with the first active edge
  end

endmodule

//--- tb_ita_ctrl.sv
/* directed tests for the tile sequencing controller
   expected tile order and in-flight count come from a beat-indexed model */

`timescale 1ns/1ns

`include "ita_settings.svh"

module tb_ita_ctrl;

  localparam int period_ns      = 20;
  localparam int beats_per_tile = `ITA_BEATS_PER_TILE;
  localparam int fifo_depth     = `ITA_FIFO_DEPTH;
  localparam int total_beats    = 4 * 192; // four layer runs of 192 beats
  localparam int watchdog_ns    = total_beats * 4 * period_ns + 20000;
  localparam int hold_cycles    = 20; // stalled cycles before outputs drain

  logic clk;
  logic rst_n;
  ita_ctrl_pkg::ctrl_t ctrl;
  logic inp_valid, weight_valid, bias_valid, oup_valid, oup_ready;
  logic inp_ready, weight_ready, bias_ready, calc_en;
  ita_ctrl_pkg::step_e step;
  ita_ctrl_pkg::tile_pos_t tile_pos;

  int mismatch_cnt = 0;
  int other_cnt    = 0;
  int inflight     = 0; // outputs the DUT should still wait for

  tb_clk_gen #(.period_ns(period_ns), .reset_cycles(4)) u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  ita_ctrl_top dut0 (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .ctrl_i         (ctrl),
    .inp_valid_i    (inp_valid),
    .inp_ready_o    (inp_ready),
    .weight_valid_i (weight_valid),
    .weight_ready_o (weight_ready),
    .bias_valid_i   (bias_valid),
    .bias_ready_o   (bias_ready),
    .oup_valid_i    (oup_valid),
    .oup_ready_i    (oup_ready),
    .step_o         (step),
    .calc_en_o      (calc_en),
    .tile_pos_o     (tile_pos)
  );

  task automatic check_equal(input int actual, input int expected, input string msg);
    if (actual != expected) begin
      mismatch_cnt++;
      $display("Mismatch at %0t ns: %s, got %0d, expected %0d", $time, msg, actual, expected);
    end
  endtask

  task automatic run_layer(input ita_ctrl_pkg::layer_e layer, input int s, input int e,
                           input int p, input int f, input bit gaps, input bit hold_out,
                           input string name);
    int n1, total, beats, local_b, tile_i, inner, outer, inner_lim, x_lim;
    int cycle, held_pushes, stalled_cycles;
    bit ff, started, done, held, allow, exp_active, exp_last, push, pop;
    ita_ctrl_pkg::step_e exp_step;
    ff = (layer == ita_ctrl_pkg::Feedforward);
    n1 = ff ? s * f * e * beats_per_tile : s * p * e * beats_per_tile;
    total = ff ? 2 * n1 : n1;
    beats = 0;
    cycle = 0;
    held_pushes = 0;
    stalled_cycles = 0;
    started = 1'b0;
    done = 1'b0;
    held = hold_out;
    while (!done) begin
      @(posedge clk);
      ctrl.start   <= (cycle == 0);
      ctrl.layer   <= layer;
      ctrl.tile_s  <= ita_ctrl_pkg::counter_t'(s);
      ctrl.tile_e  <= ita_ctrl_pkg::counter_t'(e);
      ctrl.tile_p  <= ita_ctrl_pkg::counter_t'(p);
      ctrl.tile_f  <= ita_ctrl_pkg::counter_t'(f);
      inp_valid    <= gaps ? (($urandom % 4) != 0) : 1'b1;
      weight_valid <= gaps ? (($urandom % 4) != 0) : 1'b1;
      bias_valid   <= gaps ? (($urandom % 4) != 0) : 1'b1;
      oup_valid    <= !held;
      oup_ready    <= 1'b1;
      @(negedge clk);
      cycle++;
      exp_active = (cycle >= 2) && (beats < total); // Idle is left on the edge after start
      check_equal(int'(step != ita_ctrl_pkg::Idle), int'(exp_active), {name, ": step active"});
      allow = exp_active && (inflight < fifo_depth);
      check_equal(int'(inp_ready), int'(allow && weight_valid), {name, ": inp_ready"});
      check_equal(int'(weight_ready), int'(allow && inp_valid), {name, ": weight_ready"});
      check_equal(int'(bias_ready), int'(allow && weight_valid), {name, ": bias_ready"});
      check_equal(int'(calc_en), int'(allow && inp_valid && weight_valid && bias_valid),
                  {name, ": calc_en"});
      exp_last = 1'b0;
      if (calc_en) begin
        local_b = (beats < n1) ? beats : beats - n1;
        if (!ff) begin
          exp_step = ita_ctrl_pkg::MatMul;
          inner_lim = e;
          x_lim = p;
        end else if (beats < n1) begin
          exp_step = ita_ctrl_pkg::F1;
          inner_lim = e;
          x_lim = f;
        end else begin
          exp_step = ita_ctrl_pkg::F2; // inner loop over the hidden tiles
          inner_lim = f;
          x_lim = e;
        end
        tile_i = local_b / beats_per_tile;
        inner  = tile_i % inner_lim;
        outer  = tile_i / inner_lim;
        exp_last = (inner == inner_lim - 1);
        check_equal(int'(step), int'(exp_step), {name, ": step"});
        check_equal(int'(tile_pos.tile_x), outer % x_lim, {name, ": tile_x"});
        check_equal(int'(tile_pos.tile_y), outer / x_lim, {name, ": tile_y"});
        check_equal(int'(tile_pos.inner_tile), inner, {name, ": inner_tile"});
        check_equal(int'(tile_pos.first_inner), int'(inner == 0), {name, ": first_inner"});
        check_equal(int'(tile_pos.last_inner), int'(exp_last), {name, ": last_inner"});
        beats++;
      end
      push = calc_en && exp_last;
      pop  = oup_valid && oup_ready;
      if (held && push) held_pushes++;
      if (push && !pop) begin
        inflight++;
      end else if (pop && !push && inflight != 0) begin
        inflight--;
      end
      if (held && exp_active && !inp_ready) stalled_cycles++;
      if (stalled_cycles == hold_cycles) held = 1'b0; // let the outputs drain
      if (step != ita_ctrl_pkg::Idle) begin
        started = 1'b1;
      end else if (started) begin
        done = 1'b1;
      end
    end
    check_equal(beats, total, {name, ": beats before Idle"});
    if (hold_out) begin
      check_equal(held_pushes, fifo_depth, {name, ": last-inner beats while outputs held"});
      if (stalled_cycles < hold_cycles) begin
        other_cnt++;
        $display("Error at %0t ns: %s, the inputs never stalled while outputs were held",
                 $time, name);
      end
    end
  endtask

  task automatic test_reset();
    @(posedge rst_n);
    repeat (3) begin
      @(posedge clk);
      inp_valid    <= 1'b1;
      weight_valid <= 1'b1;
      bias_valid   <= 1'b1;
      @(negedge clk);
      check_equal(int'(step), int'(ita_ctrl_pkg::Idle), "reset: step");
      check_equal(int'(calc_en), 0, "reset: calc_en");
      check_equal(int'(inp_ready), 0, "reset: inp_ready");
      check_equal(int'(weight_ready), 0, "reset: weight_ready");
      check_equal(int'(bias_ready), 0, "reset: bias_ready");
    end
  endtask

  task automatic test_linear();
    run_layer(ita_ctrl_pkg::Linear, 2, 3, 2, 0, 1'b0, 1'b0, "linear");
  endtask

  task automatic test_feedforward();
    run_layer(ita_ctrl_pkg::Feedforward, 1, 2, 0, 3, 1'b0, 1'b0, "feedforward");
  endtask

  task automatic test_backpressure();
    run_layer(ita_ctrl_pkg::Linear, 2, 3, 2, 0, 1'b0, 1'b1, "back-pressure");
  endtask

  task automatic test_random_gaps();
    run_layer(ita_ctrl_pkg::Linear, 2, 3, 2, 0, 1'b1, 1'b0, "random gaps");
  endtask

  initial begin
    #(watchdog_ns);
    $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    void'($urandom(22805));
    ctrl         <= '0;
    inp_valid    <= 1'b0;
    weight_valid <= 1'b0;
    bias_valid   <= 1'b0;
    oup_valid    <= 1'b0;
    oup_ready    <= 1'b0;
    test_reset();
    test_linear();
    test_feedforward();
    test_backpressure();
    test_random_gaps();
    $display("Closing report: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
